//--- logic/npu_defs.svh
`ifndef NPU_DEFS_SVH
`define NPU_DEFS_SVH

// int8 lanes per operand vector, 16 lanes give a 128-bit vector
`define NPU_LANES 16

`define NPU_SDRAM_DATA_W 128  // one SDRAM read beat
`define NPU_ADDR_W 24         // SDRAM word address

// CSR byte offsets, decoded on the low four address bits
`define NPU_CSR_CTRL   4'h0
`define NPU_CSR_FADDR  4'h4
`define NPU_CSR_STATUS 4'h8

`endif

//--- logic/eu_pkg.sv
`include "npu_defs.svh"

package eu_pkg;

    // requantization parameters, scales are unsigned Q8.8
    typedef struct packed {
        logic [15:0]       s_a;
        logic [15:0]       s_b;
        logic signed [7:0] z_tot;
    } quant_params_t;

    typedef logic signed [7:0] lane_t;
    typedef lane_t [`NPU_LANES-1:0] vec_t;  // lane i sits in bits 8*i+7:8*i

    typedef struct packed {
        logic [1:0] we;    // bit 0 loads operand a, bit 1 loads operand b
        vec_t       data;
    } opnd_wr_t;

    typedef struct packed {
        logic                   fetch;  // single-cycle pulses
        logic                   exec;
        logic [`NPU_ADDR_W-1:0] fetch_addr;
    } eu_ctrl_t;

endpackage

//--- logic/mem_pkg.sv
`include "npu_defs.svh"

package mem_pkg;

    // held steady until accepted with ready
    typedef struct packed {
        logic                   valid;
        logic [`NPU_ADDR_W-1:0] addr;
    } sdram_rd_req_t;

    // one beat per request, the consumer cannot stall it
    typedef struct packed {
        logic                         valid;
        logic [`NPU_SDRAM_DATA_W-1:0] data;
    } sdram_rd_rsp_t;

endpackage

//--- logic/eu_csr.sv
`timescale 1ns/1ps
`include "npu_defs.svh"

module eu_csr (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_awvalid,
    input  logic [31:0]      i_awaddr,
    input  logic             i_wvalid,
    input  logic [31:0]      i_wdata,
    input  logic [3:0]       i_wstrb,
    input  logic             i_bready,
    input  logic             i_arvalid,
    input  logic [31:0]      i_araddr,
    input  logic             i_rready,
    output logic             o_awready,
    output logic             o_wready,
    output logic             o_bvalid,
    output logic [1:0]       o_bresp,
    output logic             o_arready,
    output logic             o_rvalid,
    output logic [31:0]      o_rdata,
    output logic [1:0]       o_rresp,
    input  logic             i_fetch_done,
    input  logic             i_exec_done,
    output eu_pkg::eu_ctrl_t o_ctrl
);
    logic                   aw_held;
    logic                   w_held;
    logic [3:0]             aw_addr_q;
    logic [31:0]            w_data_q;
    logic [3:0]             w_strb_q;
    logic                   wr_fire;
    logic [1:0]             start_pend;  // ctrl bits waiting for the B handshake
    logic                   fetch_pulse;
    logic                   exec_pulse;
    logic [`NPU_ADDR_W-1:0] faddr_q;
    logic                   fetch_done_q;
    logic                   exec_done_q;
    logic                   fetch_busy;
    logic [2:0]             exec_cnt;    // execs issued but not finished
    logic                   busy;
    logic [31:0]            rd_mux;

    // address and data are taken in either order, one write at a time
    assign o_awready = !aw_held && !o_bvalid;
    assign o_wready  = !w_held && !o_bvalid;
    assign wr_fire   = aw_held && w_held;
    assign o_bresp   = 2'b00;
    assign o_arready = !o_rvalid;
    assign o_rresp   = 2'b00;
    assign busy      = fetch_busy || (exec_cnt != 3'd0);
    assign o_ctrl    = '{fetch: fetch_pulse, exec: exec_pulse, fetch_addr: faddr_q};

    always_ff @(posedge clk) begin
        if (i_awvalid && o_awready) aw_addr_q <= i_awaddr[3:0];
        if (i_wvalid && o_wready) begin
            w_data_q <= i_wdata;
            w_strb_q <= i_wstrb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_held     <= 1'b0;
            w_held      <= 1'b0;
            o_bvalid    <= 1'b0;
            start_pend  <= 2'b00;
            fetch_pulse <= 1'b0;
            exec_pulse  <= 1'b0;
            faddr_q     <= '0;
        end else begin
            fetch_pulse <= 1'b0;
            exec_pulse  <= 1'b0;
            if (i_awvalid && o_awready) aw_held <= 1'b1;
            if (i_wvalid && o_wready) w_held <= 1'b1;
            if (wr_fire) begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                o_bvalid <= 1'b1;
                start_pend <= (aw_addr_q == `NPU_CSR_CTRL && w_strb_q[0]) ?
                              w_data_q[1:0] : 2'b00;
                if (aw_addr_q == `NPU_CSR_FADDR) begin
                    for (int b = 0; b < 3; b++) begin
                        if (w_strb_q[b]) faddr_q[b*8 +: 8] <= w_data_q[b*8 +: 8];
                    end
                end
            end
            // start pulses go out once the host has taken the response
            if (o_bvalid && i_bready) begin
                o_bvalid    <= 1'b0;
                fetch_pulse <= start_pend[0];
                exec_pulse  <= start_pend[1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_done_q <= 1'b0;
            exec_done_q  <= 1'b0;
            fetch_busy   <= 1'b0;
            exec_cnt     <= 3'd0;
        end else begin
            if (fetch_pulse) fetch_done_q <= 1'b0;  // a new start wins over a late done
            else if (i_fetch_done) fetch_done_q <= 1'b1;
            if (exec_pulse) exec_done_q <= 1'b0;
            else if (i_exec_done) exec_done_q <= 1'b1;

            // the fetcher drops a start while busy, so one flag is enough here
            if (fetch_pulse) fetch_busy <= 1'b1;
            else if (i_fetch_done) fetch_busy <= 1'b0;
            exec_cnt <= exec_cnt + 3'(exec_pulse) - 3'(i_exec_done);
        end
    end

    always_comb begin
        case (i_araddr[3:0])
            `NPU_CSR_FADDR:  rd_mux = 32'(faddr_q);
            `NPU_CSR_STATUS: rd_mux = {29'd0, busy, exec_done_q, fetch_done_q};
            default:         rd_mux = 32'd0;  // ctrl reads back as zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rvalid <= 1'b0;
        end else if (i_arvalid && o_arready) begin
            o_rvalid <= 1'b1;
        end else if (o_rvalid && i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_arvalid && o_arready) o_rdata <= rd_mux;
    end

endmodule

//--- logic/add_param_fetch.sv
`timescale 1ns/1ps
`include "npu_defs.svh"

module add_param_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_start,
    input  logic [`NPU_ADDR_W-1:0]  i_addr,
    output mem_pkg::sdram_rd_req_t  o_rd_req,
    input  logic                    i_rd_ready,
    input  mem_pkg::sdram_rd_rsp_t  i_rd_rsp,
    output eu_pkg::quant_params_t   o_params,
    output logic                    o_valid,
    output logic                    o_done
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t                 state;
    logic [`NPU_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            o_done <= 1'b0;
        end else begin
            o_done <= o_valid;  // done follows the beat by one cycle
            case (state)
                ST_IDLE: if (i_start) state <= ST_REQ;
                ST_REQ:  if (i_rd_ready) state <= ST_WAIT;
                ST_WAIT: if (i_rd_rsp.valid) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the address is only taken from idle, a start while busy is dropped
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_start) addr_q <= i_addr;
    end

    assign o_rd_req = '{valid: (state == ST_REQ), addr: addr_q};

    // beat layout is s_a in 15:0, s_b in 31:16, z_tot in 39:32
    assign o_valid  = (state == ST_WAIT) && i_rd_rsp.valid;
    assign o_params = '{s_a:   i_rd_rsp.data[15:0],
                        s_b:   i_rd_rsp.data[31:16],
                        z_tot: i_rd_rsp.data[39:32]};

endmodule

//--- logic/quant_add.sv
`timescale 1ns/1ps
`include "npu_defs.svh"

module quant_add (
    input  logic                  clk,
    input  logic                  rst_n,
    input  eu_pkg::quant_params_t i_params,
    input  eu_pkg::vec_t          i_a,
    input  eu_pkg::vec_t          i_b,
    input  logic                  i_start,
    output eu_pkg::vec_t          o_c,
    output logic                  o_done
);
    localparam int LANES  = `NPU_LANES;
    localparam int PROD_W = 25;          // int8 times unsigned 16-bit scale
    localparam int SUM_W  = PROD_W + 1;
    localparam int SHR_W  = SUM_W - 8;
    localparam int ACC_W  = SHR_W + 1;

    logic                     v1;
    logic                     v2;
    logic signed [7:0]        z1;  // zero point rides along with its operation
    logic signed [7:0]        z2;
    logic signed [PROD_W-1:0] prod_a [LANES];
    logic signed [PROD_W-1:0] prod_b [LANES];
    logic signed [SUM_W-1:0]  sum_c  [LANES];
    logic signed [SHR_W-1:0]  shr    [LANES];
    logic signed [ACC_W-1:0]  acc_c  [LANES];
    eu_pkg::vec_t             c_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1     <= 1'b0;
            v2     <= 1'b0;
            o_done <= 1'b0;
        end else begin
            v1     <= i_start;
            v2     <= v1;
            o_done <= v2;
        end
    end

    // stage 1 registers the scaled products of every lane
    always_ff @(posedge clk) begin
        z1 <= i_params.z_tot;
        for (int i = 0; i < LANES; i++) begin
            prod_a[i] <= i_a[i] * $signed({1'b0, i_params.s_a});
            prod_b[i] <= i_b[i] * $signed({1'b0, i_params.s_b});
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sum_c[i] = SUM_W'(prod_a[i]) + SUM_W'(prod_b[i]) + SUM_W'(128);  // round half up
        end
    end

    // stage 2 drops the Q8.8 fraction
    always_ff @(posedge clk) begin
        z2 <= z1;
        for (int i = 0; i < LANES; i++) begin
            shr[i] <= SHR_W'(sum_c[i] >>> 8);
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            acc_c[i] = ACC_W'(shr[i]) + ACC_W'(z2);
            if (acc_c[i] > ACC_W'(127)) c_next[i] = 8'sd127;
            else if (acc_c[i] < -ACC_W'(128)) c_next[i] = -8'sd128;
            else c_next[i] = acc_c[i][7:0];
        end
    end

    // stage 3, the result holds until the next operation completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_c <= '0;
        end else if (v2) begin
            o_c <= c_next;
        end
    end

endmodule

//--- logic/add_eu.sv
`timescale 1ns/1ps

module add_eu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  eu_pkg::eu_ctrl_t       i_ctrl,
    input  eu_pkg::opnd_wr_t       i_opnd_wr,
    output mem_pkg::sdram_rd_req_t o_rd_req,
    input  logic                   i_rd_ready,
    input  mem_pkg::sdram_rd_rsp_t i_rd_rsp,
    output eu_pkg::vec_t           o_c,
    output logic                   o_fetch_done,
    output logic                   o_exec_done
);
    eu_pkg::quant_params_t params_nf;  // straight from the returning beat
    eu_pkg::quant_params_t params_q;
    logic                  fetch_valid;
    eu_pkg::vec_t          a_q;
    eu_pkg::vec_t          b_q;

    add_param_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (i_ctrl.fetch),
        .i_addr     (i_ctrl.fetch_addr),
        .o_rd_req   (o_rd_req),
        .i_rd_ready (i_rd_ready),
        .i_rd_rsp   (i_rd_rsp),
        .o_params   (params_nf),
        .o_valid    (fetch_valid),
        .o_done     (o_fetch_done)
    );

    always_ff @(posedge clk) begin
        if (fetch_valid) params_q <= params_nf;
    end

    // one shared data bus, so a wins when both enables are set
    always_ff @(posedge clk) begin
        if (i_opnd_wr.we[0]) a_q <= i_opnd_wr.data;
        else if (i_opnd_wr.we[1]) b_q <= i_opnd_wr.data;
    end

    quant_add u_add (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_params (params_q),
        .i_a      (a_q),
        .i_b      (b_q),
        .i_start  (i_ctrl.exec),
        .o_c      (o_c),
        .o_done   (o_exec_done)
    );

endmodule

//--- logic/add_eu_top.sv
`timescale 1ns/1ps

module add_eu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_awvalid,
    input  logic [31:0]            i_awaddr,
    input  logic                   i_wvalid,
    input  logic [31:0]            i_wdata,
    input  logic [3:0]             i_wstrb,
    input  logic                   i_bready,
    input  logic                   i_arvalid,
    input  logic [31:0]            i_araddr,
    input  logic                   i_rready,
    output logic                   o_awready,
    output logic                   o_wready,
    output logic                   o_bvalid,
    output logic [1:0]             o_bresp,
    output logic                   o_arready,
    output logic                   o_rvalid,
    output logic [31:0]            o_rdata,
    output logic [1:0]             o_rresp,
    output mem_pkg::sdram_rd_req_t o_rd_req,
    input  logic                   i_rd_ready,
    input  mem_pkg::sdram_rd_rsp_t i_rd_rsp,
    input  eu_pkg::opnd_wr_t       i_opnd_wr,
    output eu_pkg::vec_t           o_c
);
    eu_pkg::eu_ctrl_t ctrl;
    logic             fetch_done;
    logic             exec_done;

    eu_csr u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_awvalid    (i_awvalid),
        .i_awaddr     (i_awaddr),
        .i_wvalid     (i_wvalid),
        .i_wdata      (i_wdata),
        .i_wstrb      (i_wstrb),
        .i_bready     (i_bready),
        .i_arvalid    (i_arvalid),
        .i_araddr     (i_araddr),
        .i_rready     (i_rready),
        .o_awready    (o_awready),
        .o_wready     (o_wready),
        .o_bvalid     (o_bvalid),
        .o_bresp      (o_bresp),
        .o_arready    (o_arready),
        .o_rvalid     (o_rvalid),
        .o_rdata      (o_rdata),
        .o_rresp      (o_rresp),
        .i_fetch_done (fetch_done),
        .i_exec_done  (exec_done),
        .o_ctrl       (ctrl)
    );

    // the host sees result validity only through STATUS
    add_eu u_eu (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ctrl       (ctrl),
        .i_opnd_wr    (i_opnd_wr),
        .o_rd_req     (o_rd_req),
        .i_rd_ready   (i_rd_ready),
        .i_rd_rsp     (i_rd_rsp),
        .o_c          (o_c),
        .o_fetch_done (fetch_done),
        .o_exec_done  (exec_done)
    );

endmodule

//--- dv/sdram_param_model.sv
`timescale 1ns/1ps
`include "npu_defs.svh"

module sdram_param_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_pkg::sdram_rd_req_t i_req,
    output logic                   o_ready,
    output mem_pkg::sdram_rd_rsp_t o_rsp
);
    logic [`NPU_SDRAM_DATA_W-1:0] gold [0:29];
    logic [`NPU_SDRAM_DATA_W-1:0] mem [logic [`NPU_ADDR_W-1:0]];  // only the golden addresses

    function automatic logic [`NPU_SDRAM_DATA_W-1:0] lookup(input logic [`NPU_ADDR_W-1:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return {8'hA5, {5{addr}}};  // unmapped words still differ per address
    endfunction

    // one process owns the random stream, so the run repeats exactly
    initial begin
        logic                   accepted;
        logic                   pending;
        int                     lat;
        logic [`NPU_ADDR_W-1:0] addr_q;
        accepted = 1'b0;
        pending  = 1'b0;
        lat      = 0;
        addr_q   = '0;
        o_ready  = 1'b0;
        o_rsp    = '0;
        $readmemh("dv/add_golden.hex", gold);
        for (int k = 0; k < 6; k++) begin
            mem[gold[5*k][`NPU_ADDR_W-1:0]] = gold[5*k+1];
        end
        void'($urandom(32'hff94));
        forever begin
            @(negedge clk);
            o_rsp.valid = 1'b0;
            if (!rst_n) begin
                accepted = 1'b0;
                pending  = 1'b0;
                o_ready  = 1'b0;
            end else begin
                if (accepted) begin
                    lat      = 2 + int'($urandom % 5);  // beat comes a few cycles later
                    pending  = 1'b1;
                    accepted = 1'b0;
                end
                if (pending) begin
                    if (lat == 0) begin
                        o_rsp   = '{valid: 1'b1, data: lookup(addr_q)};
                        pending = 1'b0;
                    end else begin
                        lat--;
                    end
                end
                o_ready  = !pending && ($urandom % 3 != 0);
                accepted = o_ready && i_req.valid;  // the next rising edge takes it
                if (accepted) addr_q = i_req.addr;
            end
        end
    end

endmodule

//--- dv/tb_add_eu_top.sv
`timescale 1ns/1ps
`include "npu_defs.svh"

module tb_add_eu_top;
    localparam int NCASES = 6;
    localparam int TMO    = 200;
    localparam logic [31:0] CTRL   = 32'(`NPU_CSR_CTRL);
    localparam logic [31:0] FADDR  = 32'(`NPU_CSR_FADDR);
    localparam logic [31:0] STATUS = 32'(`NPU_CSR_STATUS);

    logic                   clk;
    logic                   rst_n;
    logic                   awvalid;
    logic [31:0]            awaddr;
    logic                   wvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [31:0]            araddr;
    logic                   rready;
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    mem_pkg::sdram_rd_req_t rd_req;
    logic                   rd_ready;
    mem_pkg::sdram_rd_rsp_t rd_rsp;
    eu_pkg::opnd_wr_t       opnd_wr;
    eu_pkg::vec_t           c;
    logic [127:0]           gold [0:5*NCASES-1];
    int                     exec_seen;  // exec done pulses seen since reset

    add_eu_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .i_awvalid(awvalid), .i_awaddr(awaddr), .i_wvalid(wvalid), .i_wdata(wdata),
        .i_wstrb(wstrb), .i_bready(bready), .i_arvalid(arvalid), .i_araddr(araddr),
        .i_rready(rready), .o_awready(awready), .o_wready(wready), .o_bvalid(bvalid),
        .o_bresp(bresp), .o_arready(arready), .o_rvalid(rvalid), .o_rdata(rdata),
        .o_rresp(rresp), .o_rd_req(rd_req), .i_rd_ready(rd_ready), .i_rd_rsp(rd_rsp),
        .i_opnd_wr(opnd_wr), .o_c(c)
    );

    sdram_param_model u_sdram (
        .clk(clk), .rst_n(rst_n), .i_req(rd_req), .o_ready(rd_ready), .o_rsp(rd_rsp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // the done pulse lasts one cycle, so each one is seen at exactly one falling edge
    always @(negedge clk) begin
        if (dut0.exec_done === 1'b1) exec_seen++;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_vec(input string name, input eu_pkg::vec_t got, input eu_pkg::vec_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_params(input string name, input eu_pkg::quant_params_t got,
                                input eu_pkg::quant_params_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // beat layout from the register map, s_a low, then s_b, then z_tot
    function automatic eu_pkg::quant_params_t unpack_beat(input logic [127:0] beat);
        eu_pkg::quant_params_t p;
        p.s_a   = beat[15:0];
        p.s_b   = beat[31:16];
        p.z_tot = beat[39:32];
        return p;
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        int   n;
        logic aw_hit;
        logic w_hit;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        n = 0;
        while (awvalid || wvalid) begin
            n++;
            if (n > TMO) stop_run("AXI write address or data was never accepted");
            aw_hit = awready;  // readies are stable on the falling edge
            w_hit  = wready;
            @(negedge clk);
            if (aw_hit) awvalid = 1'b0;
            if (w_hit) wvalid = 1'b0;
        end
        bready = 1'b1;
        n = 0;
        while (!bvalid) begin
            n++;
            if (n > TMO) stop_run("AXI write response never arrived");
            @(negedge clk);
        end
        check_resp("BRESP", bresp, 2'b00);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        int n;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        n = 0;
        while (!arready) begin
            n++;
            if (n > TMO) stop_run("AXI read address was never accepted");
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            n++;
            if (n > TMO) stop_run("AXI read data never arrived");
            @(negedge clk);
        end
        data = rdata;
        check_resp("RRESP", rresp, 2'b00);
        @(negedge clk);
        rready = 1'b0;
    endtask

    // want holds busy, exec_done and fetch_done
    task automatic poll_status(input logic [2:0] want, output logic [31:0] st);
        int n;
        n = 0;
        axi_read(STATUS, st);
        while (st[2:0] !== want) begin
            n++;
            if (n > TMO) stop_run("STATUS never reached the expected flags");
            axi_read(STATUS, st);
        end
    endtask

    task automatic load_operand(input logic [1:0] we, input eu_pkg::vec_t data);
        @(negedge clk);
        opnd_wr = '{we: we, data: data};
        @(negedge clk);
        opnd_wr.we = 2'b00;
    endtask

    initial begin
        logic [31:0] st;
        logic        old_exec;
        int          n_exec;
        exec_seen = 0;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        opnd_wr = '0;
        $readmemh("dv/add_golden.hex", gold);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        axi_read(STATUS, st);
        check_status("STATUS after reset", st, 32'h0);
        axi_write(FADDR, 32'h00a5c396);
        axi_read(FADDR, st);
        check_status("FADDR readback", st, 32'h00a5c396);

        for (int k = 0; k < NCASES; k++) begin
            old_exec = (k > 0);
            axi_write(FADDR, gold[5*k][31:0]);
            axi_write(CTRL, 32'h1);
            axi_read(STATUS, st);  // fetch still running, so fetch_done is clear
            check_status("STATUS during fetch", st, {29'd0, 1'b1, old_exec, 1'b0});
            poll_status({1'b0, old_exec, 1'b1}, st);
            check_status("STATUS after fetch", st, {29'd0, 1'b0, old_exec, 1'b1});
            check_params("params_q", dut0.u_eu.params_q, unpack_beat(gold[5*k+1]));

            load_operand(2'b10, gold[5*k+3]);
            // case 3 loads a with both enables, b must keep its value
            load_operand((k == 3) ? 2'b11 : 2'b01, gold[5*k+2]);
            axi_write(CTRL, 32'h2);
            poll_status(3'b011, st);
            check_vec("o_c", c, gold[5*k+4]);
            axi_write(CTRL, 32'h2);
            poll_status(3'b011, st);
            check_vec("o_c repeated exec", c, gold[5*k+4]);
        end

        n_exec = exec_seen;
        axi_write(CTRL, 32'h2);
        axi_write(CTRL, 32'h2);
        axi_write(CTRL, 32'h2);
        poll_status(3'b011, st);
        check_status("STATUS after three execs", st, 32'h3);
        check_count("exec_done pulses", exec_seen - n_exec, 3);
        check_vec("o_c after three execs", c, gold[5*(NCASES-1)+4]);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- dv/add_golden.hex
// six cases of five 128-bit words: fetch address, parameter beat, vector a, vector b, expected c
// beat holds s_a in 15:0, s_b in 31:16, z_tot in 39:32; vector lane i sits in bits 8*i+7:8*i
00000000_00000000_00000000_00000100
00000000_00000000_00000000_01000100
0A14FB03_0A14FB03_0A14FB03_0A14FB03
64E20204_64E20204_64E20204_64E20204
6EF6FD07_6EF6FD07_6EF6FD07_6EF6FD07
00000000_00000000_00000000_00000204
00000000_00000000_00000005_01800200
00FF3264_00FF3264_00FF3264_00FF3264
01FF1464_01FF1464_01FF1464_01FF1464
07027F7F_07027F7F_07027F7F_07027F7F
00000000_00000000_00000000_00000308
00000000_00000000_000000F6_01000300
FE0A809C_FE0A809C_FE0A809C_FE0A809C
01FB00CE_01FB00CE_01FB00CE_01FB00CE
F10F8080_F10F8080_F10F8080_F10F8080
00000000_00000000_00000000_0000040C
00000000_00000000_00000001_00400080
807FF907_807FF907_807FF907_807FF907
9C64F808_9C64F808_9C64F808_9C64F808
A85AFC07_A85AFC07_A85AFC07_A85AFC07
00000000_00000000_00000000_00001000
00000000_00000000_000000FD_00AB0155
C040FF01_C040FF01_C040FF01_C040FF01
7FC00101_7FC00101_7FC00101_7FC00101
FD28FCFF_FD28FCFF_FD28FCFF_FD28FCFF
00000000_00000000_00000000_00ABCDE0
00000000_00000000_0000007F_0000FFFF
02FF0100_02FF0100_02FF0100_02FF0100
08070605_08070605_08070605_08070605
7F807F7F_7F807F7F_7F807F7F_7F807F7F

//--- src.f
+incdir+logic
logic/eu_pkg.sv
logic/mem_pkg.sv
logic/eu_csr.sv
logic/add_param_fetch.sv
logic/quant_add.sv
logic/add_eu.sv
logic/add_eu_top.sv
dv/sdram_param_model.sv
dv/tb_add_eu_top.sv

//--- Makefile
SIM := obj_dir/Vtb_add_eu_top
SRCS := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): src.f $(SRCS)
	verilator --binary --top-module tb_add_eu_top -f src.f

run: $(SIM) dv/add_golden.hex
	./$(SIM)

clean:
	rm -rf obj_dir
